// ==== project.f ====
+incdir+.
analogizer_pkg.sv
rgb_to_ypbpr.sv
video_output_select.sv
cart_pin_driver.sv
analogizer_top.sv
analogizer_checker.sv
analogizer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module analogizer_tb -o analogizer_sim
./obj_dir/analogizer_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// ==== analogizer_tb.sv ====
`include "analogizer_consts.svh"

module analogizer_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PIX_W = `ANALOGIZER_PIX_W;
	localparam int DAC_W = `ANALOGIZER_DAC_W;
	localparam int LAT = `ANALOGIZER_LATENCY;
	localparam int RESET_CYC = 8;
	localparam int OFF_CYC = 40;
	localparam int RGB_CYC = 2000;
	localparam int YPBPR_CYC = 2000;
	localparam int FALLBACK_CYC = 1000;
	localparam int MIX_CYC = 2000;
	localparam int TOGGLE_CYC = 1000;
	localparam int CYCLE_LIMIT = RESET_CYC + OFF_CYC + RGB_CYC + YPBPR_CYC
		+ FALLBACK_CYC + MIX_CYC + TOGGLE_CYC + 100;

	logic video_clk = 1'b0;
	logic i_arst_n, i_ena;
	logic [`ANALOGIZER_MODE_W-1:0] i_analog_video_type;
	analogizer_pkg::pix_t i_r, i_g, i_b;
	logic i_hsync, i_csync, i_blank_n;
	logic [7:0] o_cart_bank1, o_cart_bank2, o_cart_bank3;
	logic o_cart_bank1_oe, o_cart_bank2_oe, o_cart_bank3_oe;

	logic [15:0] lfsr = 16'd41024;
	int cycles = 0;
	// pixels in the pipe, oldest first, packed as code, r, g, b, hsync, csync, blank_n
	logic [30:0] in_flight [$];

	// 8 ns pixel clock
	always #4 video_clk = ~video_clk;

	analogizer_top UUT (.*);

	task automatic stop_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// guard against a stuck run
	always @(posedge video_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			stop_with_failure();
		end
	end

	// galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step for every bit handed out
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		take_bits = v;
	endfunction

	// kind 1 rgbs/rgsb, 2 ypbpr, 3 unused codes, else any code
	function automatic logic [3:0] draw_code(input int kind);
		logic [3:0] c;
		c = 4'(take_bits(4));
		case (kind)
			1: c[2:1] = 2'b00;
			2: c = {c[3], 3'b010};
			3: begin
				while (c[2:0] < 3'd3) begin
					c = 4'(take_bits(4));
				end
			end
			default: c = c;
		endcase
		draw_code = c;
	endfunction

	// floor of the weighted sum over 256, offset, clamped, top dac bits
	function automatic analogizer_pkg::dac_t conv(input int kr, input int kg, input int kb,
		input int ofs, input analogizer_pkg::pix_t r, input analogizer_pkg::pix_t g,
		input analogizer_pkg::pix_t b);
		int v;
		v = ((kr * int'(r) + kg * int'(g) + kb * int'(b)) >>> 8) + ofs;
		if (v < 0)
			v = 0;
		if (v > (1 << PIX_W) - 1)
			v = (1 << PIX_W) - 1;
		conv = analogizer_pkg::dac_t'(v >>> (PIX_W - DAC_W));
	endfunction

	// bank bytes for one pixel, returned as bank3, bank2, bank1
	function automatic logic [23:0] expected_banks(input logic [30:0] s);
		logic [3:0] code;
		analogizer_pkg::pix_t r, g, b;
		logic hs, cs, bl, hs_pin, vs_pin, bl_pin;
		analogizer_pkg::dac_t dr, dg, db;
		{code, r, g, b, hs, cs, bl} = s;
		// black while blanking
		if (!bl) begin
			r = '0;
			g = '0;
			b = '0;
		end
		dr = r[PIX_W-1 -: DAC_W];
		dg = g[PIX_W-1 -: DAC_W];
		db = b[PIX_W-1 -: DAC_W];
		hs_pin = cs;
		vs_pin = 1'b1;
		bl_pin = bl;
		if (code[2:0] == 3'd1) begin
			// sync on green
			hs_pin = 1'b1;
			vs_pin = cs;
		end else if (code[2:0] == 3'd2) begin
			dr = conv(`ANALOGIZER_PR_R, `ANALOGIZER_PR_G, `ANALOGIZER_PR_B,
				`ANALOGIZER_CHROMA_OFS, r, g, b);
			dg = conv(`ANALOGIZER_Y_R, `ANALOGIZER_Y_G, `ANALOGIZER_Y_B, 0, r, g, b);
			db = conv(`ANALOGIZER_PB_R, `ANALOGIZER_PB_G, `ANALOGIZER_PB_B,
				`ANALOGIZER_CHROMA_OFS, r, g, b);
			hs_pin = 1'b1;
			vs_pin = cs;
			bl_pin = 1'b1;
		end else if (code[2:0] != 3'd0) begin
			// blue screen
			dr = '0;
			dg = '0;
			db = '1;
			hs_pin = hs;
		end
		// forwarded clock bit reads low in the low phase
		expected_banks = {dr, hs_pin, vs_pin, db[0], bl_pin, dg, 3'b000, db[DAC_W-1:1]};
	endfunction

	task automatic check_byte(input string test, input string what, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp) begin
			$display("Mismatch %s %s expected 8'h%02h actual 8'h%02h", test, what, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string test, input string what, input logic exp,
		input logic act);
		if (act !== exp) begin
			$display("Mismatch %s %s expected %b actual %b", test, what, exp, act);
			stop_with_failure();
		end
	endtask

	// drive one pixel at the falling edge, then check the pixel from 3 cycles back
	task automatic step(input string test, input logic arst_n, input logic ena,
		input logic [`ANALOGIZER_MODE_W-1:0] code);
		logic [23:0] exp;
		logic [30:0] oldest;
		logic drive;
		@(negedge video_clk);
		i_arst_n = arst_n;
		i_ena = ena;
		i_analog_video_type = code;
		i_r = arst_n ? take_bits(8) : 8'd0;
		i_g = arst_n ? take_bits(8) : 8'd0;
		i_b = arst_n ? take_bits(8) : 8'd0;
		i_hsync = arst_n && take_bits(1) != 8'd0;
		i_csync = arst_n && take_bits(1) != 8'd0;
		// roughly a quarter of the pixels blanked
		i_blank_n = arst_n && take_bits(2) != 8'd0;
		in_flight.push_back({code, i_r, i_g, i_b, i_hsync, i_csync, i_blank_n});
		#2;
		// the pipe keeps moving while the banks are released
		oldest = in_flight.pop_front();
		drive = i_arst_n & i_ena;
		exp = drive ? expected_banks(oldest) : 24'h0;
		check_byte(test, "bank3", exp[23:16], o_cart_bank3);
		check_byte(test, "bank2", exp[15:8], o_cart_bank2);
		check_byte(test, "bank1", exp[7:0], o_cart_bank1);
		check_bit(test, "bank1_oe", drive, o_cart_bank1_oe);
		check_bit(test, "bank2_oe", drive, o_cart_bank2_oe);
		check_bit(test, "bank3_oe", drive, o_cart_bank3_oe);
	endtask

	initial begin
		i_arst_n = 1'b0;
		i_ena = 1'b0;
		i_analog_video_type = '0;
		i_r = '0;
		i_g = '0;
		i_b = '0;
		i_hsync = 1'b0;
		i_csync = 1'b0;
		i_blank_n = 1'b0;
		// pipe starts in its reset state
		repeat (LAT) in_flight.push_back(31'd0);
		repeat (RESET_CYC) step("reset", 1'b0, 1'b1, 4'd0);
		repeat (OFF_CYC) step("disabled", 1'b1, 1'b0, draw_code(1));
		repeat (RGB_CYC) step("rgbs_rgsb", 1'b1, 1'b1, draw_code(1));
		repeat (YPBPR_CYC) step("ypbpr", 1'b1, 1'b1, draw_code(2));
		repeat (FALLBACK_CYC) step("fallback", 1'b1, 1'b1, draw_code(3));
		repeat (MIX_CYC) step("mode_switch", 1'b1, 1'b1, draw_code(0));
		repeat (TOGGLE_CYC) step("enable_toggle", 1'b1, take_bits(2) != 8'd0, draw_code(0));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== analogizer_checker.sv ====
`include "analogizer_consts.svh"

module analogizer_checker (
	input logic                          video_clk,
	input logic                          i_arst_n,
	input logic [`ANALOGIZER_MODE_W-1:0] i_mode_code,
	input logic [7:0]                    i_bank1,
	input logic                          i_bank1_oe,
	input logic [7:0]                    i_bank2,
	input logic                          i_bank2_oe,
	input logic [7:0]                    i_bank3,
	input logic                          i_bank3_oe
);
	timeunit 1ns;
	timeprecision 1ps;

	// codes 2 and 10
	logic code_ypbpr;
	assign code_ypbpr = (i_mode_code[2:0] == 3'd2);

	// one enable for the whole port
	oe_equal: assert property (@(posedge video_clk)
		(i_bank1_oe == i_bank2_oe) && (i_bank2_oe == i_bank3_oe))
		else $error("bank enables differ");

	// released banks drive nothing
	bank1_zero: assert property (@(posedge video_clk) !i_bank1_oe |-> i_bank1 == 8'h00)
		else $error("bank 1 not zero while released");
	bank2_zero: assert property (@(posedge video_clk) !i_bank2_oe |-> i_bank2 == 8'h00)
		else $error("bank 2 not zero while released");
	bank3_zero: assert property (@(posedge video_clk) !i_bank3_oe |-> i_bank3 == 8'h00)
		else $error("bank 3 not zero while released");

	// sync rides on luma, hs pin held high
	ypbpr_hs_high: assert property (@(posedge video_clk) disable iff (!i_arst_n)
		(i_bank3_oe && $past(i_arst_n, 3) && $past(code_ypbpr, 3)) |-> i_bank3[1])
		else $error("hs bit low in ypbpr mode");

endmodule

bind analogizer_top analogizer_checker u_analogizer_checker (
	.video_clk   (video_clk),
	.i_arst_n    (i_arst_n),
	.i_mode_code (i_analog_video_type),
	.i_bank1     (o_cart_bank1),
	.i_bank1_oe  (o_cart_bank1_oe),
	.i_bank2     (o_cart_bank2),
	.i_bank2_oe  (o_cart_bank2_oe),
	.i_bank3     (o_cart_bank3),
	.i_bank3_oe  (o_cart_bank3_oe)
);

// ==== analogizer_top.sv ====
`include "analogizer_consts.svh"

module analogizer_top (
	input  logic                         video_clk,
	input  logic                         i_arst_n,
	input  logic                         i_ena,
	input  logic [`ANALOGIZER_MODE_W-1:0] i_analog_video_type,
	input  analogizer_pkg::pix_t          i_r,
	input  analogizer_pkg::pix_t          i_g,
	input  analogizer_pkg::pix_t          i_b,
	input  logic                         i_hsync,
	input  logic                         i_csync,
	input  logic                         i_blank_n,
	output logic [7:0]                   o_cart_bank1,
	output logic                         o_cart_bank1_oe,
	output logic [7:0]                   o_cart_bank2,
	output logic                         o_cart_bank2_oe,
	output logic [7:0]                   o_cart_bank3,
	output logic                         o_cart_bank3_oe
);

	// dac side of the adapter
	analogizer_pkg::dac_t dac_r, dac_g, dac_b;
	logic hs_pin, vs_pin, blank_n_pin;

	video_output_select u_video_output_select (
		.video_clk           (video_clk),
		.i_arst_n            (i_arst_n),
		.i_analog_video_type (i_analog_video_type),
		.i_r                 (i_r),
		.i_g                 (i_g),
		.i_b                 (i_b),
		.i_hsync             (i_hsync),
		.i_csync             (i_csync),
		.i_blank_n           (i_blank_n),
		.o_dac_r             (dac_r),
		.o_dac_g             (dac_g),
		.o_dac_b             (dac_b),
		.o_hs_pin            (hs_pin),
		.o_vs_pin            (vs_pin),
		.o_blank_n_pin       (blank_n_pin)
	);

	// cartridge port, no registers past this point
	cart_pin_driver u_cart_pin_driver (
		.video_clk       (video_clk),
		.i_arst_n        (i_arst_n),
		.i_ena           (i_ena),
		.i_dac_r         (dac_r),
		.i_dac_g         (dac_g),
		.i_dac_b         (dac_b),
		.i_hs_pin        (hs_pin),
		.i_vs_pin        (vs_pin),
		.i_blank_n_pin   (blank_n_pin),
		.o_cart_bank1    (o_cart_bank1),
		.o_cart_bank1_oe (o_cart_bank1_oe),
		.o_cart_bank2    (o_cart_bank2),
		.o_cart_bank2_oe (o_cart_bank2_oe),
		.o_cart_bank3    (o_cart_bank3),
		.o_cart_bank3_oe (o_cart_bank3_oe)
	);

endmodule

// ==== cart_pin_driver.sv ====
`include "analogizer_consts.svh"

module cart_pin_driver (
	input  logic                 video_clk,
	input  logic                 i_arst_n,
	input  logic                 i_ena,
	input  analogizer_pkg::dac_t i_dac_r,
	input  analogizer_pkg::dac_t i_dac_g,
	input  analogizer_pkg::dac_t i_dac_b,
	input  logic                 i_hs_pin,
	input  logic                 i_vs_pin,
	input  logic                 i_blank_n_pin,
	output logic [7:0]           o_cart_bank1,
	output logic                 o_cart_bank1_oe,
	output logic [7:0]           o_cart_bank2,
	output logic                 o_cart_bank2_oe,
	output logic [7:0]           o_cart_bank3,
	output logic                 o_cart_bank3_oe
);

	localparam int DAC_W = `ANALOGIZER_DAC_W;

	logic drive;
	logic [7:0] bank1_d, bank2_d, bank3_d;

	// banks released in reset or while the adapter is off
	assign drive = i_arst_n & i_ena;

	// bank 3, red then hsync and vsync
	assign bank3_d = {i_dac_r, i_hs_pin, i_vs_pin};
	// bank 2, blue lsb, blank and green
	assign bank2_d = {i_dac_b[0], i_blank_n_pin, i_dac_g};
	// bank 1, controller pins unused, pixel clock to the dac, upper blue
	assign bank1_d = {2'b00, video_clk, i_dac_b[DAC_W-1:1]};

	assign o_cart_bank1 = drive ? bank1_d : '0;
	assign o_cart_bank2 = drive ? bank2_d : '0;
	assign o_cart_bank3 = drive ? bank3_d : '0;

	assign o_cart_bank1_oe = drive;
	assign o_cart_bank2_oe = drive;
	assign o_cart_bank3_oe = drive;

endmodule

// ==== video_output_select.sv ====
`include "analogizer_consts.svh"

module video_output_select (
	input  logic                         video_clk,
	input  logic                         i_arst_n,
	input  logic [`ANALOGIZER_MODE_W-1:0] i_analog_video_type,
	input  analogizer_pkg::pix_t          i_r,
	input  analogizer_pkg::pix_t          i_g,
	input  analogizer_pkg::pix_t          i_b,
	input  logic                         i_hsync,
	input  logic                         i_csync,
	input  logic                         i_blank_n,
	output analogizer_pkg::dac_t          o_dac_r,
	output analogizer_pkg::dac_t          o_dac_g,
	output analogizer_pkg::dac_t          o_dac_b,
	output logic                         o_hs_pin,
	output logic                         o_vs_pin,
	output logic                         o_blank_n_pin
);

	localparam int LAT   = `ANALOGIZER_LATENCY;
	localparam int PIX_W = `ANALOGIZER_PIX_W;
	localparam int DAC_W = `ANALOGIZER_DAC_W;

	analogizer_pkg::mode_e mode_in;
	analogizer_pkg::pix_t  mask_r, mask_g, mask_b;
	analogizer_pkg::pix_t  conv_y, conv_pb, conv_pr;

	// delay line, index LAT-1 lines up with the converter output
	analogizer_pkg::mode_e mode_q [LAT];
	analogizer_pkg::pix_t  r_q [LAT];
	analogizer_pkg::pix_t  g_q [LAT];
	analogizer_pkg::pix_t  b_q [LAT];
	logic [LAT-1:0]        hs_q, cs_q, bl_q;

	// codes 0/8, 1/9 and 2/10 pick a standard, y/c and scandoubler codes fall through
	always_comb begin
		case (i_analog_video_type)
			4'h0, 4'h8: mode_in = analogizer_pkg::MODE_RGBS;
			4'h1, 4'h9: mode_in = analogizer_pkg::MODE_RGSB;
			4'h2, 4'hA: mode_in = analogizer_pkg::MODE_YPBPR;
			default:    mode_in = analogizer_pkg::MODE_FALLBACK;
		endcase
	end

	// some cores leave colour on the bus during blanking
	assign mask_r = i_blank_n ? i_r : '0;
	assign mask_g = i_blank_n ? i_g : '0;
	assign mask_b = i_blank_n ? i_b : '0;

	rgb_to_ypbpr u_rgb_to_ypbpr (
		.video_clk (video_clk),
		.i_arst_n  (i_arst_n),
		.i_r       (mask_r),
		.i_g       (mask_g),
		.i_b       (mask_b),
		.o_y       (conv_y),
		.o_pb      (conv_pb),
		.o_pr      (conv_pr)
	);

	// mode travels with its pixel so a switch lands on the right pixel
	always_ff @(posedge video_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < LAT; i++) begin
				mode_q[i] <= analogizer_pkg::MODE_RGBS;
				r_q[i]    <= '0;
				g_q[i]    <= '0;
				b_q[i]    <= '0;
			end
			hs_q <= '0;
			cs_q <= '0;
			bl_q <= '0;
		end else begin
			mode_q[0] <= mode_in;
			r_q[0]    <= mask_r;
			g_q[0]    <= mask_g;
			b_q[0]    <= mask_b;
			for (int i = 1; i < LAT; i++) begin
				mode_q[i] <= mode_q[i-1];
				r_q[i]    <= r_q[i-1];
				g_q[i]    <= g_q[i-1];
				b_q[i]    <= b_q[i-1];
			end
			hs_q <= {hs_q[LAT-2:0], i_hsync};
			cs_q <= {cs_q[LAT-2:0], i_csync};
			bl_q <= {bl_q[LAT-2:0], i_blank_n};
		end
	end

	// per-mode pin choice on the last stage
	always_comb begin
		case (mode_q[LAT-1])
			analogizer_pkg::MODE_RGBS: begin
				o_dac_r       = r_q[LAT-1][PIX_W-1 -: DAC_W];
				o_dac_g       = g_q[LAT-1][PIX_W-1 -: DAC_W];
				o_dac_b       = b_q[LAT-1][PIX_W-1 -: DAC_W];
				o_hs_pin      = cs_q[LAT-1];
				o_vs_pin      = 1'b1;
				o_blank_n_pin = bl_q[LAT-1];
			end
			analogizer_pkg::MODE_RGSB: begin
				o_dac_r       = r_q[LAT-1][PIX_W-1 -: DAC_W];
				o_dac_g       = g_q[LAT-1][PIX_W-1 -: DAC_W];
				o_dac_b       = b_q[LAT-1][PIX_W-1 -: DAC_W];
				// csync to the dac sync pin for the sog switch
				o_hs_pin      = 1'b1;
				o_vs_pin      = cs_q[LAT-1];
				o_blank_n_pin = bl_q[LAT-1];
			end
			analogizer_pkg::MODE_YPBPR: begin
				// pr on red, y on green, pb on blue
				o_dac_r       = conv_pr[PIX_W-1 -: DAC_W];
				o_dac_g       = conv_y[PIX_W-1 -: DAC_W];
				o_dac_b       = conv_pb[PIX_W-1 -: DAC_W];
				o_hs_pin      = 1'b1;
				o_vs_pin      = cs_q[LAT-1];
				// the dac would blank the sync tip otherwise
				o_blank_n_pin = 1'b1;
			end
			default: begin
				// blue screen, raw hsync
				o_dac_r       = '0;
				o_dac_g       = '0;
				o_dac_b       = '1;
				o_hs_pin      = hs_q[LAT-1];
				o_vs_pin      = 1'b1;
				o_blank_n_pin = bl_q[LAT-1];
			end
		endcase
	end

endmodule

// ==== rgb_to_ypbpr.sv ====
`include "analogizer_consts.svh"

module rgb_to_ypbpr (
	input  logic                video_clk,
	input  logic                i_arst_n,
	input  analogizer_pkg::pix_t i_r,
	input  analogizer_pkg::pix_t i_g,
	input  analogizer_pkg::pix_t i_b,
	output analogizer_pkg::pix_t o_y,
	output analogizer_pkg::pix_t o_pb,
	output analogizer_pkg::pix_t o_pr
);

	localparam int PIX_W   = `ANALOGIZER_PIX_W;
	// unsigned pixel times a coefficient below 256 in magnitude
	localparam int PROD_W  = PIX_W + 10;
	// headroom for three products
	localparam int SUM_W   = PROD_W + 2;
	// after dropping the 8 fraction bits
	localparam int RES_W   = SUM_W - 8;
	localparam int PIX_MAX = (1 << PIX_W) - 1;

	// rows y, pb, pr; columns r, g, b
	localparam int COEF [3][3] = '{
		'{`ANALOGIZER_Y_R,  `ANALOGIZER_Y_G,  `ANALOGIZER_Y_B},
		'{`ANALOGIZER_PB_R, `ANALOGIZER_PB_G, `ANALOGIZER_PB_B},
		'{`ANALOGIZER_PR_R, `ANALOGIZER_PR_G, `ANALOGIZER_PR_B}
	};
	// luma sits on black, chroma on mid-scale
	localparam int OFS [3] = '{0, `ANALOGIZER_CHROMA_OFS, `ANALOGIZER_CHROMA_OFS};

	logic signed [PROD_W-1:0] prod_q [3][3];
	logic signed [SUM_W-1:0]  row_sum [3];
	logic signed [RES_W-1:0]  row_scaled [3];
	logic signed [RES_W-1:0]  scaled_q [3];
	analogizer_pkg::pix_t     clamp_q [3];

	// zero extended pixel times signed weight
	function automatic logic signed [PROD_W-1:0] mul(input analogizer_pkg::pix_t p, input int c);
		logic signed [PROD_W-1:0] ps;
		logic signed [PROD_W-1:0] cs;
		ps = $signed({{(PROD_W-PIX_W){1'b0}}, p});
		cs = PROD_W'(c);
		mul = ps * cs;
	endfunction

	// saturate to the 8-bit pixel range
	function automatic analogizer_pkg::pix_t clamp(input logic signed [RES_W-1:0] v);
		if (v < 0)
			clamp = '0;
		else if (v > PIX_MAX)
			clamp = '1;
		else
			clamp = v[PIX_W-1:0];
	endfunction

	// stage 1, nine products
	always_ff @(posedge video_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int row = 0; row < 3; row++) begin
				for (int col = 0; col < 3; col++) begin
					prod_q[row][col] <= '0;
				end
			end
		end else begin
			for (int row = 0; row < 3; row++) begin
				prod_q[row][0] <= mul(i_r, COEF[row][0]);
				prod_q[row][1] <= mul(i_g, COEF[row][1]);
				prod_q[row][2] <= mul(i_b, COEF[row][2]);
			end
		end
	end

	// row sums, arithmetic shift floors toward minus infinity
	always_comb begin
		for (int row = 0; row < 3; row++) begin
			row_sum[row] = SUM_W'(prod_q[row][0]) + SUM_W'(prod_q[row][1])
				+ SUM_W'(prod_q[row][2]);
			row_scaled[row] = RES_W'(row_sum[row] >>> 8) + RES_W'(OFS[row]);
		end
	end

	// stage 2 holds the scaled sums, stage 3 the clamped result
	always_ff @(posedge video_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int row = 0; row < 3; row++) begin
				scaled_q[row] <= '0;
				clamp_q[row]  <= '0;
			end
		end else begin
			for (int row = 0; row < 3; row++) begin
				scaled_q[row] <= row_scaled[row];
				clamp_q[row]  <= clamp(scaled_q[row]);
			end
		end
	end

	assign o_y  = clamp_q[0];
	assign o_pb = clamp_q[1];
	assign o_pr = clamp_q[2];

endmodule

// ==== analogizer_pkg.sv ====
`include "analogizer_consts.svh"

package analogizer_pkg;

	// one colour channel from the core, also used for y, pb and pr
	typedef logic [`ANALOGIZER_PIX_W-1:0] pix_t;

	// one channel as seen by the video dac on the adapter
	typedef logic [`ANALOGIZER_DAC_W-1:0] dac_t;

	// output standard after decoding the analog video type code
	// rgbs: csync on the hsync pin
	// rgsb: csync on the dac sync pin, sync on green
	// ypbpr: converted colour space, sync on luma
	// fallback: blue screen with raw hsync
	typedef enum logic [1:0] {
		MODE_RGBS     = 2'd0,
		MODE_RGSB     = 2'd1,
		MODE_YPBPR    = 2'd2,
		MODE_FALLBACK = 2'd3
	} mode_e;

endpackage

// ==== analogizer_consts.svh ====
`ifndef ANALOGIZER_CONSTS_SVH
`define ANALOGIZER_CONSTS_SVH

// colour channel width as delivered by the core
`define ANALOGIZER_PIX_W 8

// dac channel width, the upper bits of each channel survive
`define ANALOGIZER_DAC_W 6

// width of the analog video type code
`define ANALOGIZER_MODE_W 4

// pixel in to bank pins, in video clocks
`define ANALOGIZER_LATENCY 3

// luma weights, units of 1/256
`define ANALOGIZER_Y_R 77
`define ANALOGIZER_Y_G 150
`define ANALOGIZER_Y_B 29

// pb weights, units of 1/256
`define ANALOGIZER_PB_R (-43)
`define ANALOGIZER_PB_G (-85)
`define ANALOGIZER_PB_B 128

// pr weights, units of 1/256
`define ANALOGIZER_PR_R 128
`define ANALOGIZER_PR_G (-107)
`define ANALOGIZER_PR_B (-21)

// mid-scale offset for the colour difference channels
`define ANALOGIZER_CHROMA_OFS 128

`endif
